/* list.f */
+incdir+testbench
rtl/div_pkg.sv
rtl/count_leading_zeros.sv
rtl/div_result_fixup.sv
rtl/div_result_cache.sv
rtl/div_sequencer.sv
rtl/int_divider_unit.sv
testbench/tb_int_divider_unit.sv

/* rtl/count_leading_zeros.sv */
`timescale 1ns/1ps
`default_nettype none

module count_leading_zeros
   #(
   parameter int lg_n = 7
   )
   (
   input  logic [(1 << lg_n)-1:0] in,
   output logic [lg_n:0]          y
   );

   localparam int n = 1 << lg_n;

   logic found;

   // scan from the top bit down and stop at the first one
   always_comb
   begin
      y = (lg_n + 1)'(n);
      found = 1'b0;
      for (int i = n - 1; i >= 0; i--)
      begin
         if (!found && in[i])
         begin
            y = (lg_n + 1)'(n - 1 - i);
            found = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/div_pkg.sv */
`default_nettype none

package div_pkg;

   // operand and result width
   localparam int xlen = 64;
   localparam int lg_xlen = 6;

   // remainder and divisor registers hold two operand widths
   localparam int dxlen = 2 * xlen;

   // tags carried through with each operation
   localparam int lg_rob_entries = 6;
   localparam int lg_prf_entries = 7;

   typedef enum logic [2:0]
   {
      idle        = 3'd0,
      skip        = 3'd1,
      iterate     = 3'd2,
      pack        = 3'd3,
      cached_pack = 3'd4,
      wait_wb     = 3'd5
   } div_state_t;

endpackage

`default_nettype wire

/* rtl/div_result_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_cache
   (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [div_pkg::xlen-1:0] mag_a,
   input  logic [div_pkg::xlen-1:0] mag_b,
   input  logic                     op_signed,
   input  logic                     record,
   input  logic [div_pkg::xlen-1:0] quot_raw,
   input  logic [div_pkg::xlen-1:0] rem_raw,
   output logic                     cache_hit,
   output logic [div_pkg::xlen-1:0] cached_quot,
   output logic [div_pkg::xlen-1:0] cached_rem
   );

   import div_pkg::*;

   logic            r_valid;
   logic [xlen-1:0] r_key_a;
   logic [xlen-1:0] r_key_b;
   logic            r_key_signed;
   logic [xlen-1:0] r_quot;
   logic [xlen-1:0] r_rem;

   // entry becomes valid on the first recorded result
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= 1'b0;
      end
      else if (record)
      begin
         r_valid <= 1'b1;
      end
   end

   // keys are the magnitudes plus signedness
   always_ff @(posedge clk)
   begin
      if (record)
      begin
         r_key_a <= mag_a;
         r_key_b <= mag_b;
         r_key_signed <= op_signed;
         r_quot <= quot_raw;
         r_rem <= rem_raw;
      end
   end

   assign cache_hit = r_valid
                      & (r_key_a == mag_a)
                      & (r_key_b == mag_b)
                      & (r_key_signed == op_signed);

   // unsigned results, signs are applied again downstream
   assign cached_quot = r_quot;
   assign cached_rem = r_rem;

endmodule

`default_nettype wire

/* rtl/div_result_fixup.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_fixup
   (
   input  logic [div_pkg::xlen-1:0] fix_quot,
   input  logic [div_pkg::xlen-1:0] fix_rem,
   input  logic                     neg_quot,
   input  logic                     neg_rem,
   input  logic                     sel_rem,
   input  logic                     word_op,
   output logic [div_pkg::xlen-1:0] fixed_result
   );

   import div_pkg::*;

   logic [xlen-1:0] quot_signed;
   logic [xlen-1:0] rem_signed;
   logic [xlen-1:0] picked;

   // quotient sign from the operand signs, remainder sign from the dividend
   assign quot_signed = neg_quot ? (~fix_quot + xlen'(1)) : fix_quot;
   assign rem_signed = neg_rem ? (~fix_rem + xlen'(1)) : fix_rem;

   assign picked = sel_rem ? rem_signed : quot_signed;

   // word ops keep only the low half, sign-extended
   always_comb
   begin
      if (word_op)
      begin
         fixed_result = {{(xlen - 32){picked[31]}}, picked[31:0]};
      end
      else
      begin
         fixed_result = picked;
      end
   end

endmodule

`default_nettype wire

/* rtl/div_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module div_sequencer
   (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               flush,
   input  logic                               wb_slot_used,
   input  logic                               start,
   input  logic [div_pkg::xlen-1:0]           dividend,
   input  logic [div_pkg::xlen-1:0]           divisor,
   input  logic                               is_signed,
   input  logic                               is_rem,
   input  logic                               is_w,
   input  logic [div_pkg::lg_rob_entries-1:0] rob_ptr_in,
   input  logic [div_pkg::lg_prf_entries-1:0] prf_ptr_in,
   output logic [div_pkg::xlen-1:0]           result,
   output logic [div_pkg::lg_rob_entries-1:0] rob_ptr_out,
   output logic [div_pkg::lg_prf_entries-1:0] prf_ptr_out,
   output logic                               ready,
   output logic                               complete,
   output logic [div_pkg::dxlen-1:0]          rem_shifted,
   output logic [div_pkg::dxlen-1:0]          divisor_wide,
   input  logic [div_pkg::lg_xlen+1:0]        clz_rem,
   input  logic [div_pkg::lg_xlen+1:0]        clz_div,
   output logic [div_pkg::xlen-1:0]           mag_a,
   output logic [div_pkg::xlen-1:0]           mag_b,
   output logic                               op_signed,
   output logic                               record,
   output logic [div_pkg::xlen-1:0]           quot_raw,
   output logic [div_pkg::xlen-1:0]           rem_raw,
   input  logic                               cache_hit,
   input  logic [div_pkg::xlen-1:0]           cached_quot,
   input  logic [div_pkg::xlen-1:0]           cached_rem,
   output logic [div_pkg::xlen-1:0]           fix_quot,
   output logic [div_pkg::xlen-1:0]           fix_rem,
   output logic                               neg_quot,
   output logic                               neg_rem,
   output logic                               sel_rem,
   output logic                               word_op,
   input  logic [div_pkg::xlen-1:0]           fixed_result
   );

   import div_pkg::*;

   div_state_t r_state;
   div_state_t n_state;

   logic                      r_signed;
   logic                      r_neg_quot;
   logic                      r_neg_rem;
   logic                      r_is_rem;
   logic                      r_is_w;
   logic [lg_rob_entries-1:0] r_rob_ptr;
   logic [lg_prf_entries-1:0] r_prf_ptr;
   logic [xlen-1:0]           r_a;
   logic [xlen-1:0]           r_b;
   logic [dxlen-1:0]          r_rem;
   logic [dxlen-1:0]          r_div;
   logic [xlen-1:0]           r_quot;
   logic [lg_xlen+1:0]        r_idx;
   logic [xlen-1:0]           r_result;

   logic [xlen-1:0]    a_mag;
   logic [xlen-1:0]    b_mag;
   logic [lg_xlen+1:0] clz_delta;
   logic [lg_xlen+1:0] idx_skipped;
   logic               skip_ok;
   logic               q_bit;
   logic [dxlen-1:0]   rem_next;

   // magnitudes of signed operands
   assign a_mag = (is_signed & dividend[xlen-1]) ? (~dividend + xlen'(1)) : dividend;
   assign b_mag = (is_signed & divisor[xlen-1]) ? (~divisor + xlen'(1)) : divisor;

   assign rem_shifted = {r_rem[dxlen-2:0], 1'b0};
   assign divisor_wide = r_div;

   // high zero bits of the dividend give known zero quotient bits
   assign clz_delta = clz_rem - clz_div;
   assign skip_ok = clz_delta <= (lg_xlen + 2)'(xlen);
   assign idx_skipped = r_idx - clz_delta;

   // one restoring step
   assign q_bit = rem_shifted >= r_div;
   assign rem_next = q_bit ? (rem_shifted - r_div) : rem_shifted;

   always_comb
   begin
      n_state = r_state;
      case (r_state)
         idle:
         begin
            if (start)
            begin
               n_state = skip;
            end
         end
         skip:
         begin
            // index below zero means every quotient bit was skipped
            n_state = (skip_ok && idx_skipped[lg_xlen+1]) ? pack : iterate;
         end
         iterate:
         begin
            if (cache_hit || flush)
            begin
               n_state = cached_pack;
            end
            else if (r_idx == '0)
            begin
               n_state = pack;
            end
         end
         pack, cached_pack:
         begin
            n_state = wait_wb;
         end
         wait_wb:
         begin
            if (!wb_slot_used)
            begin
               n_state = idle;
            end
         end
         default:
         begin
            n_state = idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= idle;
      end
      else
      begin
         r_state <= n_state;
      end
   end

   always_ff @(posedge clk)
   begin
      case (r_state)
         idle:
         begin
            if (start)
            begin
               r_a <= a_mag;
               r_b <= b_mag;
               r_rem <= {{xlen{1'b0}}, a_mag};
               r_div <= {b_mag, {xlen{1'b0}}};
               r_quot <= '0;
               r_idx <= (lg_xlen + 2)'(xlen - 1);
               r_signed <= is_signed;
               r_neg_quot <= is_signed & (dividend[xlen-1] ^ divisor[xlen-1]);
               r_neg_rem <= is_signed & dividend[xlen-1];
               r_is_rem <= is_rem;
               r_is_w <= is_w;
               r_rob_ptr <= rob_ptr_in;
               r_prf_ptr <= prf_ptr_in;
            end
         end
         skip:
         begin
            if (skip_ok)
            begin
               r_rem <= r_rem << clz_delta;
               r_idx <= idx_skipped;
            end
         end
         iterate:
         begin
            r_rem <= rem_next;
            r_quot[r_idx[lg_xlen-1:0]] <= q_bit;
            r_idx <= r_idx - (lg_xlen + 2)'(1);
         end
         pack, cached_pack:
         begin
            r_result <= fixed_result;
         end
         default:
         begin
         end
      endcase
   end

   // cache side
   assign mag_a = r_a;
   assign mag_b = r_b;
   assign op_signed = r_signed;
   assign record = r_state == pack;
   assign quot_raw = r_quot;
   assign rem_raw = r_rem[dxlen-1:xlen];

   // fixup takes cached values on the early-out path
   assign fix_quot = (r_state == cached_pack) ? cached_quot : r_quot;
   assign fix_rem = (r_state == cached_pack) ? cached_rem : r_rem[dxlen-1:xlen];
   assign neg_quot = r_neg_quot;
   assign neg_rem = r_neg_rem;
   assign sel_rem = r_is_rem;
   assign word_op = r_is_w;

   assign ready = (r_state == idle) & !start;
   assign complete = (r_state == wait_wb) & !wb_slot_used;
   assign result = r_result;
   assign rob_ptr_out = r_rob_ptr;
   assign prf_ptr_out = r_prf_ptr;

endmodule

`default_nettype wire

/* rtl/int_divider_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module int_divider_unit
   (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               flush,
   input  logic                               wb_slot_used,
   input  logic                               start,
   input  logic                               is_signed,
   input  logic                               is_rem,
   input  logic                               is_w,
   input  logic [div_pkg::xlen-1:0]           dividend,
   input  logic [div_pkg::xlen-1:0]           divisor,
   input  logic [div_pkg::lg_rob_entries-1:0] rob_ptr_in,
   input  logic [div_pkg::lg_prf_entries-1:0] prf_ptr_in,
   output logic [div_pkg::xlen-1:0]           result,
   output logic [div_pkg::lg_rob_entries-1:0] rob_ptr_out,
   output logic [div_pkg::lg_prf_entries-1:0] prf_ptr_out,
   output logic                               ready,
   output logic                               complete
   );

   import div_pkg::*;

   logic [dxlen-1:0]   rem_shifted;
   logic [dxlen-1:0]   divisor_wide;
   logic [lg_xlen+1:0] clz_rem;
   logic [lg_xlen+1:0] clz_div;
   logic [xlen-1:0]    mag_a;
   logic [xlen-1:0]    mag_b;
   logic               op_signed;
   logic               record;
   logic [xlen-1:0]    quot_raw;
   logic [xlen-1:0]    rem_raw;
   logic               cache_hit;
   logic [xlen-1:0]    cached_quot;
   logic [xlen-1:0]    cached_rem;
   logic [xlen-1:0]    fix_quot;
   logic [xlen-1:0]    fix_rem;
   logic               neg_quot;
   logic               neg_rem;
   logic               sel_rem;
   logic               word_op;
   logic [xlen-1:0]    fixed_result;

   div_sequencer u_sequencer
      (
      .clk          (clk),
      .reset        (reset),
      .flush        (flush),
      .wb_slot_used (wb_slot_used),
      .start        (start),
      .dividend     (dividend),
      .divisor      (divisor),
      .is_signed    (is_signed),
      .is_rem       (is_rem),
      .is_w         (is_w),
      .rob_ptr_in   (rob_ptr_in),
      .prf_ptr_in   (prf_ptr_in),
      .result       (result),
      .rob_ptr_out  (rob_ptr_out),
      .prf_ptr_out  (prf_ptr_out),
      .ready        (ready),
      .complete     (complete),
      .rem_shifted  (rem_shifted),
      .divisor_wide (divisor_wide),
      .clz_rem      (clz_rem),
      .clz_div      (clz_div),
      .mag_a        (mag_a),
      .mag_b        (mag_b),
      .op_signed    (op_signed),
      .record       (record),
      .quot_raw     (quot_raw),
      .rem_raw      (rem_raw),
      .cache_hit    (cache_hit),
      .cached_quot  (cached_quot),
      .cached_rem   (cached_rem),
      .fix_quot     (fix_quot),
      .fix_rem      (fix_rem),
      .neg_quot     (neg_quot),
      .neg_rem      (neg_rem),
      .sel_rem      (sel_rem),
      .word_op      (word_op),
      .fixed_result (fixed_result)
      );

   // leading zeros of the shifted remainder and of the aligned divisor
   count_leading_zeros #(.lg_n(lg_xlen + 1)) u_clz_rem
      (
      .in (rem_shifted),
      .y  (clz_rem)
      );

   count_leading_zeros #(.lg_n(lg_xlen + 1)) u_clz_div
      (
      .in (divisor_wide),
      .y  (clz_div)
      );

   div_result_cache u_cache
      (
      .clk         (clk),
      .reset       (reset),
      .mag_a       (mag_a),
      .mag_b       (mag_b),
      .op_signed   (op_signed),
      .record      (record),
      .quot_raw    (quot_raw),
      .rem_raw     (rem_raw),
      .cache_hit   (cache_hit),
      .cached_quot (cached_quot),
      .cached_rem  (cached_rem)
      );

   div_result_fixup u_fixup
      (
      .fix_quot     (fix_quot),
      .fix_rem      (fix_rem),
      .neg_quot     (neg_quot),
      .neg_rem      (neg_rem),
      .sel_rem      (sel_rem),
      .word_op      (word_op),
      .fixed_result (fixed_result)
      );

endmodule

`default_nettype wire

/* testbench/div_ref_model.svh */
`ifndef div_ref_model_svh
`define div_ref_model_svh

// next state of a 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   logic fb;
   fb = s[31] ^ s[21] ^ s[1] ^ s[0];
   return {s[30:0], fb};
endfunction

// truncating division on magnitudes, signs applied afterwards
function automatic logic [xlen-1:0] ref_divide
   (
   input logic [xlen-1:0] a,
   input logic [xlen-1:0] b,
   input logic            sgn,
   input logic            rem,
   input logic            w
   );
   logic            neg_a;
   logic            neg_b;
   logic [xlen-1:0] ma;
   logic [xlen-1:0] mb;
   logic [xlen-1:0] q;
   logic [xlen-1:0] r;
   logic [xlen-1:0] res;
   neg_a = sgn & a[xlen-1];
   neg_b = sgn & b[xlen-1];
   ma = neg_a ? -a : a;
   mb = neg_b ? -b : b;
   // unsigned divide by zero: all ones and the dividend
   if (mb == '0)
   begin
      q = '1;
      r = ma;
   end
   else
   begin
      q = ma / mb;
      r = ma % mb;
   end
   if (neg_a ^ neg_b)
   begin
      q = -q;
   end
   if (neg_a)
   begin
      r = -r;
   end
   res = rem ? r : q;
   if (w)
   begin
      res = {{(xlen - 32){res[31]}}, res[31:0]};
   end
   return res;
endfunction

`endif

/* testbench/tb_int_divider_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_int_divider_unit;

   import div_pkg::*;

   `include "div_ref_model.svh"

   localparam logic [31:0] lfsr_seed = 32'h8d2610b0;
   localparam int ready_limit = 10;
   localparam int op_limit = 100;
   localparam int stall_cycles = 80;
   localparam int random_ops = 24;
   localparam int word_ops = 12;
   localparam int cache_rounds = 4;

   logic                      clk;
   logic                      reset;
   logic                      flush;
   logic                      wb_slot_used;
   logic                      start;
   logic                      is_signed;
   logic                      is_rem;
   logic                      is_w;
   logic [xlen-1:0]           dividend;
   logic [xlen-1:0]           divisor;
   logic [lg_rob_entries-1:0] rob_ptr_in;
   logic [lg_prf_entries-1:0] prf_ptr_in;
   logic [xlen-1:0]           result;
   logic [lg_rob_entries-1:0] rob_ptr_out;
   logic [lg_prf_entries-1:0] prf_ptr_out;
   logic                      ready;
   logic                      complete;

   logic [31:0] lfsr_state;
   int          errors;
   int          ops;

   int_divider_unit uut
      (
      .clk          (clk),
      .reset        (reset),
      .flush        (flush),
      .wb_slot_used (wb_slot_used),
      .start        (start),
      .is_signed    (is_signed),
      .is_rem       (is_rem),
      .is_w         (is_w),
      .dividend     (dividend),
      .divisor      (divisor),
      .rob_ptr_in   (rob_ptr_in),
      .prf_ptr_in   (prf_ptr_in),
      .result       (result),
      .rob_ptr_out  (rob_ptr_out),
      .prf_ptr_out  (prf_ptr_out),
      .ready        (ready),
      .complete     (complete)
      );

   always #2 clk = ~clk;

   // one lfsr step per bit, newest bit lands in the lsb
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // random width so that the skip step sees many quotient lengths
   function automatic logic [xlen-1:0] rand_operand();
      logic [xlen-1:0] v;
      logic [5:0]      sh;
      v = take_bits(64);
      sh = 6'(take_bits(6));
      v = v >> sh;
      if (1'(take_bits(1)))
      begin
         v = -v;
      end
      return v;
   endfunction

   task automatic report_mismatch(input string name, input string field,
                                  input logic [63:0] exp, input logic [63:0] act);
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", name, field, exp, act);
   endtask

   task automatic report_problem(input string name, input string text);
      errors++;
      $display("%s: %s", name, text);
   endtask

   task automatic finish_run();
      $display("operations: %0d, errors: %0d", ops, errors);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   endtask

   task automatic give_up(input string name, input string text);
      errors++;
      $display("timeout in %s: %s", name, text);
      finish_run();
   endtask

   // returns one cycle after a rising edge, ready to drive
   task automatic wait_ready(input string name);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!ready)
      begin
         waited++;
         if (waited > ready_limit)
         begin
            give_up(name, "the divider never became ready");
         end
         @(negedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   // one operation; latency counts falling edges from the start edge to complete
   task automatic run_op(input string name, input logic [xlen-1:0] a,
                         input logic [xlen-1:0] b, input logic sgn, input logic rem,
                         input logic w, input int stall, output int latency);
      logic [xlen-1:0]           exp_result;
      logic [lg_rob_entries-1:0] rob;
      logic [lg_prf_entries-1:0] prf;
      logic [xlen-1:0]           held_result;
      logic [lg_rob_entries-1:0] held_rob;
      logic [lg_prf_entries-1:0] held_prf;
      int                        waited;
      wait_ready(name);
      exp_result = ref_divide(a, b, sgn, rem, w);
      rob = 6'(take_bits(6));
      prf = 7'(take_bits(7));
      dividend = a;
      divisor = b;
      is_signed = sgn;
      is_rem = rem;
      is_w = w;
      rob_ptr_in = rob;
      prf_ptr_in = prf;
      wb_slot_used = stall > 0;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      // inputs move on, the unit must work from what it captured
      dividend = take_bits(64);
      divisor = take_bits(64);
      is_signed = ~sgn;
      is_rem = ~rem;
      is_w = ~w;
      rob_ptr_in = ~rob;
      prf_ptr_in = ~prf;
      ops++;
      for (int i = 0; i < stall; i++)
      begin
         @(negedge clk);
         assert (!complete)
            else report_problem(name, "complete rose while the writeback slot was taken");
         assert (!ready)
            else report_problem(name, "ready was high while the divider was busy");
      end
      if (stall > 0)
      begin
         held_result = result;
         held_rob = rob_ptr_out;
         held_prf = prf_ptr_out;
         @(posedge clk);
         #1;
         wb_slot_used = 1'b0;
      end
      waited = 1;
      @(negedge clk);
      while (!complete)
      begin
         assert (!ready)
            else report_problem(name, "ready was high while the divider was busy");
         if (waited >= op_limit)
         begin
            give_up(name, "complete never arrived");
         end
         @(negedge clk);
         waited++;
      end
      latency = waited;
      assert (result == exp_result)
         else report_mismatch(name, "result", exp_result, result);
      assert (rob_ptr_out == rob)
         else report_mismatch(name, "rob_ptr_out", 64'(rob), 64'(rob_ptr_out));
      assert (prf_ptr_out == prf)
         else report_mismatch(name, "prf_ptr_out", 64'(prf), 64'(prf_ptr_out));
      if (stall > 0)
      begin
         assert (result == held_result)
            else report_mismatch(name, "held result", held_result, result);
         assert (rob_ptr_out == held_rob)
            else report_mismatch(name, "held rob_ptr_out", 64'(held_rob), 64'(rob_ptr_out));
         assert (prf_ptr_out == held_prf)
            else report_mismatch(name, "held prf_ptr_out", 64'(held_prf), 64'(prf_ptr_out));
      end
      @(posedge clk);
      #1;
      @(negedge clk);
      assert (!complete)
         else report_problem(name, "complete stayed high for more than one cycle");
      assert (ready)
         else report_problem(name, "ready stayed low after complete");
      @(posedge clk);
      #1;
   endtask

   task automatic check_hit_latency(input string name, input int first_lat, input int lat);
      // a hit only saves time when the first run iterated longer
      if (first_lat > 4)
      begin
         assert (lat == 4)
            else report_mismatch(name, "latency", 64'(4), 64'(lat));
      end
   endtask

   initial
   begin
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      logic            sgn;
      logic            rem;
      int              lat;
      int              first_lat;
      clk = 1'b0;
      reset = 1'b1;
      flush = 1'b0;
      wb_slot_used = 1'b0;
      start = 1'b0;
      is_signed = 1'b0;
      is_rem = 1'b0;
      is_w = 1'b0;
      dividend = '0;
      divisor = '0;
      rob_ptr_in = '0;
      prf_ptr_in = '0;
      lfsr_state = lfsr_seed;
      errors = 0;
      ops = 0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      assert (ready)
         else report_problem("reset", "ready was low after reset");
      assert (!complete)
         else report_problem("reset", "complete was high after reset");
      @(posedge clk);
      #1;

      // overflow and divide-by-zero corners
      run_op("min_div_neg1", 64'h8000_0000_0000_0000, '1, 1'b1, 1'b0, 1'b0, 0, lat);
      run_op("min_rem_neg1", 64'h8000_0000_0000_0000, '1, 1'b1, 1'b1, 1'b0, 0, lat);
      a = take_bits(64);
      run_op("udiv_by_zero", a, '0, 1'b0, 1'b0, 1'b0, 0, lat);
      run_op("urem_by_zero", a, '0, 1'b0, 1'b1, 1'b0, 0, lat);

      for (int i = 0; i < random_ops + word_ops; i++)
      begin
         a = rand_operand();
         b = rand_operand();
         sgn = 1'(take_bits(1));
         rem = 1'(take_bits(1));
         if (sgn && b == '0)
         begin
            b = 64'd1;
         end
         if (i < random_ops)
         begin
            run_op(sgn ? "rand_signed" : "rand_unsigned", a, b, sgn, rem, 1'b0, 0, lat);
         end
         else
         begin
            run_op(sgn ? "word_signed" : "word_unsigned", a, b, sgn, rem, 1'b1, 0, lat);
         end
      end

      // small divisors give long quotients, so the repeat can finish early
      for (int i = 0; i < cache_rounds; i++)
      begin
         a = take_bits(64);
         b = take_bits(16) | 64'd1;
         sgn = i[0];
         if (1'(take_bits(1)))
         begin
            b = -b;
         end
         run_op("cache_first", a, b, sgn, 1'b0, 1'b0, 0, first_lat);
         run_op("cache_rem", a, b, sgn, 1'b1, 1'b0, 0, lat);
         check_hit_latency("cache_rem", first_lat, lat);
         run_op("cache_word", a, b, sgn, 1'b0, 1'b1, 0, lat);
         check_hit_latency("cache_word", first_lat, lat);
         if (sgn)
         begin
            run_op("cache_negated", -a, -b, 1'b1, 1'b1, 1'b0, 0, lat);
            check_hit_latency("cache_negated", first_lat, lat);
         end
      end

      // writeback slot held busy well past the longest divide
      a = rand_operand();
      b = rand_operand() | 64'd1;
      run_op("stall_unsigned", a, b, 1'b0, 1'b0, 1'b0, stall_cycles, lat);
      a = rand_operand();
      b = rand_operand() | 64'd1;
      run_op("stall_signed", a, b, 1'b1, 1'b1, 1'b0, stall_cycles, lat);

      finish_run();
   end

endmodule

`default_nettype wire
